//--- axiwr_umi.f
+incdir+src
src/axiwr_umi_pkg.sv
src/axiwr_ctrl.sv
src/axiwr_burst_track.sv
src/umi_req_build.sv
src/umi_resp_check.sv
src/axiwr_umi_top.sv
sim/tb_clkgen.sv
sim/axiwr_umi_asserts.sv
sim/axiwr_umi_tb.sv

//--- sim/axiwr_umi_asserts.sv
//##########################################################################
// Handshake properties of the bridge top level attached with bind
// Protocol rules only, the data is checked by the testbench
//##########################################################################

`timescale 1ns/1ps

module axiwr_umi_asserts (
  input logic clk,
  input logic nreset,
  input logic w_valid,
  input logic req_valid,
  input logic aw_ready,
  input logic b_valid,
  input logic b_ready,
  input logic resp_ready
);

  int assert_errors = 0;

  // A UMI request only exists while an AXI beat is offered
  a_req_needs_w: assert property (@(posedge clk) disable iff (!nreset)
    req_valid |-> w_valid)
    else begin
      assert_errors++;
      $error("req_valid high without w_valid");
    end

  // B stays up until taken
  a_b_hold: assert property (@(posedge clk) disable iff (!nreset)
    (b_valid && !b_ready) |=> b_valid)
    else begin
      assert_errors++;
      $error("b_valid dropped before b_ready");
    end

  // Idle and write states never overlap
  a_aw_req_excl: assert property (@(posedge clk) disable iff (!nreset)
    !(aw_ready && req_valid))
    else begin
      assert_errors++;
      $error("aw_ready and req_valid high together");
    end

  // First cycle out of reset
  a_resp_ready_reset: assert property (@(posedge clk)
    $rose(nreset) |-> !resp_ready)
    else begin
      assert_errors++;
      $error("resp_ready high right after reset");
    end

endmodule

bind axiwr_umi_top axiwr_umi_asserts u_asserts (.*);

//--- sim/axiwr_umi_tb.sv
//##########################################################################
// Testbench of the AXI write to UMI bridge, playing manager and UMI target
// Strobes are contiguous from bit 0 and one burst is sent at a time
// Ready stalls and response delays are random only in the stall test
//##########################################################################

`timescale 1ns/1ps

`include "axiwr_umi_settings.svh"

module axiwr_umi_tb;

  localparam int STRBW       = `AXIWR_DW / 8;
  // 56 beats over all tests
  localparam int TOTAL_BEATS = 56;
  localparam int CYCLE_LIMIT = 40 * TOTAL_BEATS;

  logic                     clk;
  logic                     nreset;
  axiwr_umi_pkg::axi_aw_t   aw;
  logic                     aw_valid;
  logic                     aw_ready;
  axiwr_umi_pkg::axi_w_t    w;
  logic                     w_valid;
  logic                     w_ready;
  axiwr_umi_pkg::axi_b_t    b;
  logic                     b_valid;
  logic                     b_ready;
  axiwr_umi_pkg::umi_req_t  req;
  logic                     req_valid;
  logic                     req_ready;
  axiwr_umi_pkg::umi_resp_t resp;
  logic                     resp_valid;
  logic                     resp_ready;

  // Expected traffic and the target's scripted answers {opcode, err}
  axiwr_umi_pkg::umi_req_t  exp_req_q[$];
  axiwr_umi_pkg::axi_b_t    exp_b_q[$];
  logic [6:0]               script_q[$];

  logic [31:0] rng_state = 32'h9c11;
  logic        stall_en = 1'b0;
  logic        resp_pending = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          req_count = 0;
  int          resp_count = 0;
  int          b_count = 0;
  int          bursts_open = 0;

  tb_clkgen u_clkgen (
    .clk    (clk),
    .nreset (nreset)
  );

  axiwr_umi_top u_axiwr_umi_top (
    .clk        (clk),
    .nreset     (nreset),
    .aw         (aw),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w          (w),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b          (b),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  //##########################################################################
  // Random numbers and reference model
  //##########################################################################

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Expected UMI request of one beat
  // Offset counts the bytes already sent in the burst
  function automatic axiwr_umi_pkg::umi_req_t expect_req(input axiwr_umi_pkg::axi_aw_t a,
                                                         input int offset, input int count,
                                                         input axiwr_umi_pkg::axi_w_t wb);
    axiwr_umi_pkg::umi_req_t r;
    r = '0;
    r.cmd.opcode = axiwr_umi_pkg::UMI_REQ_WRITE;
    r.cmd.len    = 8'(count - 1);
    r.cmd.prot   = a.prot[1:0];
    r.cmd.qos    = a.qos;
    r.cmd.eom    = wb.last;
    // FIXED and WRAP stay on the first address
    if (a.burst == axiwr_umi_pkg::BURST_INCR) begin
      r.dstaddr = a.addr + `AXIWR_AW'(offset);
    end else begin
      r.dstaddr = a.addr;
    end
    r.srcaddr = `AXIWR_HOSTADDR;
    r.srcaddr[STRBW-1:0] = wb.strb;
    r.data = wb.data;
    return r;
  endfunction

  // BRESP after one more response
  // The last error wins
  function automatic logic [1:0] bresp_step(input logic [1:0] prev, input logic [4:0] op,
                                            input logic [1:0] err);
    if (op != axiwr_umi_pkg::UMI_RESP_WRITE) begin
      return axiwr_umi_pkg::RESP_SLVERR;
    end
    if (err != 2'b00) begin
      return err;
    end
    return prev;
  endfunction

  task automatic check_val(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  //##########################################################################
  // AXI manager
  //##########################################################################

  // One burst with error scripts by beat index
  // Index -1 means no such error
  task automatic send_burst(input axiwr_umi_pkg::id_t id, input axiwr_umi_pkg::addr_t addr,
                            input logic [7:0] len, input logic [2:0] size,
                            input logic [1:0] burst, input int max_bytes, input int err_beat,
                            input logic [1:0] err_code, input int bad_op_beat);
    axiwr_umi_pkg::axi_aw_t a;
    axiwr_umi_pkg::axi_w_t  wb;
    axiwr_umi_pkg::axi_b_t  eb;
    logic [1:0]             br;
    logic [4:0]             op;
    logic [1:0]             er;
    int                     cap;
    int                     count;
    int                     offset;
    a       = '0;
    a.id    = id;
    a.addr  = addr;
    a.len   = len;
    a.size  = size;
    a.burst = burst;
    a.prot  = 3'(next_rand());
    a.qos   = 4'(next_rand());
    cap     = (max_bytes < (1 << size)) ? max_bytes : (1 << size);
    br      = axiwr_umi_pkg::RESP_OKAY;
    offset  = 0;
    // Address held until accepted
    @(posedge clk);
    #0.5;
    aw       = a;
    aw_valid = 1'b1;
    do @(negedge clk); while (!aw_ready);
    @(posedge clk);
    #0.5;
    aw_valid = 1'b0;
    for (int beat = 0; beat <= len; beat++) begin
      count   = 1 + int'(next_rand() % cap);
      wb.data = axiwr_umi_pkg::data_t'({next_rand(), next_rand(), next_rand(), next_rand()});
      wb.strb = axiwr_umi_pkg::strb_t'((32'd1 << count) - 1);
      wb.last = (beat == len);
      exp_req_q.push_back(expect_req(a, offset, count, wb));
      offset += count;
      // Wrong opcode is a request opcode echoed back
      op = (beat == bad_op_beat) ? axiwr_umi_pkg::UMI_REQ_WRITE : axiwr_umi_pkg::UMI_RESP_WRITE;
      er = (beat == err_beat) ? err_code : 2'b00;
      script_q.push_back({op, er});
      br = bresp_step(br, op, er);
      w       = wb;
      w_valid = 1'b1;
      do @(negedge clk); while (!w_ready);
      @(posedge clk);
      #0.5;
    end
    w_valid = 1'b0;
    eb.id   = id;
    eb.resp = br;
    exp_b_q.push_back(eb);
  endtask

  // Wait for every B of the test
  task automatic drain_bursts();
    while (exp_b_q.size() != 0) @(posedge clk);
    @(posedge clk);
    #0.5;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("Test %-14s done with %0d errors", name, errors - errs_before);
  endtask

  //##########################################################################
  // Ready stalls and UMI target
  //##########################################################################

  always @(posedge clk) begin : ready_drive
    #0.5;
    if (stall_en) begin
      req_ready = (next_rand() % 3) != 0;
      b_ready   = (next_rand() % 3) != 0;
    end else begin
      req_ready = 1'b1;
      b_ready   = 1'b1;
    end
  end

  initial begin : umi_target
    axiwr_umi_pkg::umi_req_t r;
    logic [6:0]              scr;
    int                      delay;
    forever begin
      @(negedge clk);
      if (nreset && req_valid && req_ready) begin
        r = req;
        if (script_q.size() == 0) begin
          errors++;
          $display("UMI request at %0t ns has no scripted response", $time);
          scr = {axiwr_umi_pkg::UMI_RESP_WRITE, 2'b00};
        end else begin
          scr = script_q.pop_front();
        end
        delay = stall_en ? int'(next_rand() % 6) : 0;
        // Request taken on this edge
        @(posedge clk);
        repeat (delay) @(posedge clk);
        #0.5;
        resp            = '0;
        resp.cmd.opcode = scr[6:2];
        resp.cmd.err    = scr[1:0];
        resp.dstaddr    = r.srcaddr;
        resp.srcaddr    = r.dstaddr;
        resp_valid      = 1'b1;
        do @(negedge clk); while (!resp_ready);
        @(posedge clk);
        #0.5;
        resp_valid = 1'b0;
      end
    end
  end

  //##########################################################################
  // Compare and timeout
  //##########################################################################

  // Handshakes seen at the falling edge complete on the next rising edge
  always @(negedge clk) begin : compare
    axiwr_umi_pkg::umi_req_t e;
    axiwr_umi_pkg::axi_b_t   eb;
    if (nreset) begin
      // Response channel open from the cycle after a request until its response
      check_val("resp_ready", resp_ready, resp_pending);
      // W stalls exactly when UMI stalls
      if (req_valid) begin
        check_val("w_ready vs req_ready", w_ready, req_ready);
      end
      if (req_valid && req_ready) begin
        req_count++;
        resp_pending = 1'b1;
        if (exp_req_q.size() == 0) begin
          errors++;
          $display("UMI request at %0t ns with no AXI beat behind it", $time);
        end else begin
          e = exp_req_q.pop_front();
          check_val("req cmd", req.cmd, e.cmd);
          check_val("req dstaddr", req.dstaddr, e.dstaddr);
          check_val("req srcaddr", req.srcaddr, e.srcaddr);
          check_val("req data", req.data, e.data);
        end
      end
      if (resp_valid && resp_ready) begin
        resp_count++;
        resp_pending = 1'b0;
      end
      if (aw_valid && aw_ready) begin
        if (bursts_open != 0) begin
          errors++;
          $display("Address accepted at %0t ns before the previous B handshake", $time);
        end
        bursts_open++;
      end
      if (b_valid && b_ready) begin
        b_count++;
        bursts_open--;
        check_val("responses before B", resp_count, req_count);
        if (exp_b_q.size() == 0) begin
          errors++;
          $display("Extra B response at %0t ns", $time);
        end else begin
          eb = exp_b_q.pop_front();
          check_val("b id", b.id, eb.id);
          check_val("b resp", b.resp, eb.resp);
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the bursts did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  //##########################################################################
  // Tests
  //##########################################################################

  initial begin : main
    int errs_before;
    int total_err;
    aw         = '0;
    aw_valid   = 1'b0;
    w          = '0;
    w_valid    = 1'b0;
    b_ready    = 1'b0;
    req_ready  = 1'b0;
    resp       = '0;
    resp_valid = 1'b0;
    wait (nreset === 1'b1);

    // Single partial beat
    errs_before = errors;
    send_burst(8'h11, 64'h1000_0040, 8'd0, 3'd3, axiwr_umi_pkg::BURST_INCR, STRBW - 1,
               -1, 2'b00, -1);
    drain_bursts();
    finish_test("single_beat", errs_before);

    // INCR bursts where the address steps by each beat's bytes
    errs_before = errors;
    send_burst(8'h22, 64'h2000_0100, 8'd7, 3'd3, axiwr_umi_pkg::BURST_INCR, STRBW,
               -1, 2'b00, -1);
    send_burst(8'h23, 64'h2000_0800, 8'd3, 3'd1, axiwr_umi_pkg::BURST_INCR, STRBW,
               -1, 2'b00, -1);
    drain_bursts();
    finish_test("incr_burst", errs_before);

    // Address never moves
    errs_before = errors;
    send_burst(8'h33, 64'h3000_0200, 8'd4, 3'd3, axiwr_umi_pkg::BURST_FIXED, STRBW,
               -1, 2'b00, -1);
    send_burst(8'h34, 64'h3000_0400, 8'd3, 3'd2, axiwr_umi_pkg::BURST_WRAP, STRBW,
               -1, 2'b00, -1);
    drain_bursts();
    finish_test("fixed_wrap", errs_before);

    // Error code and bad opcode bursts followed by a clean one
    errs_before = errors;
    send_burst(8'h41, 64'h4000_0000, 8'd2, 3'd3, axiwr_umi_pkg::BURST_INCR, STRBW,
               1, 2'b11, -1);
    send_burst(8'h42, 64'h4000_1000, 8'd3, 3'd3, axiwr_umi_pkg::BURST_INCR, STRBW,
               1, 2'b01, 3);
    send_burst(8'h43, 64'h4000_2000, 8'd3, 3'd3, axiwr_umi_pkg::BURST_FIXED, STRBW,
               2, 2'b11, 0);
    send_burst(8'h44, 64'h4000_3000, 8'd1, 3'd3, axiwr_umi_pkg::BURST_INCR, STRBW,
               -1, 2'b00, -1);
    drain_bursts();
    finish_test("errors", errs_before);

    // Random stalls on every channel
    errs_before = errors;
    stall_en = 1'b1;
    send_burst(8'h51, {32'h0, next_rand()}, 8'd5, 3'(next_rand() % 4),
               axiwr_umi_pkg::BURST_INCR, STRBW, -1, 2'b00, -1);
    send_burst(8'h52, {32'h0, next_rand()}, 8'd0, 3'(next_rand() % 4),
               axiwr_umi_pkg::BURST_FIXED, STRBW, -1, 2'b00, -1);
    send_burst(8'h53, {32'h0, next_rand()}, 8'd9, 3'(next_rand() % 4),
               axiwr_umi_pkg::BURST_INCR, STRBW, -1, 2'b00, -1);
    send_burst(8'h54, {32'h0, next_rand()}, 8'd3, 3'(next_rand() % 4),
               axiwr_umi_pkg::BURST_WRAP, STRBW, -1, 2'b00, -1);
    drain_bursts();
    stall_en = 1'b0;
    finish_test("backpressure", errs_before);

    // Leftover expectations mean lost beats
    if (exp_req_q.size() != 0 || script_q.size() != 0) begin
      errors++;
      $display("Some expected UMI requests never arrived");
    end
    total_err = errors + u_axiwr_umi_top.u_asserts.assert_errors;
    $display("Summary: %0d bursts, %0d beats, %0d checks, %0d errors, %0d assertion failures",
             b_count, req_count, checks, errors, u_axiwr_umi_top.u_asserts.assert_errors);
    if (total_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim/tb_clkgen.sv
//##########################################################################
// Testbench clock of 4 ns and active low reset for 3 cycles
// Reset releases 0.5 ns after a rising edge, like all other inputs
//##########################################################################

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic nreset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Held low over the first three rising edges
  initial begin
    nreset = 1'b0;
    repeat (3) @(posedge clk);
    #0.5;
    nreset = 1'b1;
  end

endmodule

//--- src/axiwr_burst_track.sv
//##########################################################################
// Burst state of the current AXI write
// Destination advances only for INCR, WRAP is treated as FIXED
// Byte count assumes contiguous LSB-aligned strobes
//##########################################################################

`timescale 1ns/1ps

module axiwr_burst_track (
  input  logic                        clk,
  input  axiwr_umi_pkg::axi_aw_t      aw,
  input  logic                        aw_fire,
  input  logic                        req_fire,
  input  logic                        w_last,
  input  axiwr_umi_pkg::beat_bytes_t  beat_bytes,
  output axiwr_umi_pkg::addr_t        dst_addr,
  output logic [1:0]                  prot,
  output logic [3:0]                  qos,
  output axiwr_umi_pkg::id_t          bid,
  output logic                        no_bytes_left
);

  // 256 beats of 128 bytes at most, plus one bit for the full count
  localparam int BLW = $clog2(256 * 128) + 1;

  logic [1:0]     burst;
  logic [BLW-1:0] len_inc;
  logic [BLW-1:0] total_bytes;
  logic [BLW-1:0] bytes_left;

  // Burst size in bytes from len and size
  assign len_inc     = {{(BLW-8){1'b0}}, aw.len} + 1'b1;
  assign total_bytes = len_inc << aw.size;

  //########################################################################
  // Address channel capture
  //########################################################################

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      bid   <= aw.id;
      burst <= aw.burst;
      // Only privileged and secure bits map onto UMI
      prot  <= aw.prot[1:0];
      qos   <= aw.qos;
    end
  end

  // Destination address of the next beat
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      dst_addr <= aw.addr;
    end else if (req_fire && (burst == axiwr_umi_pkg::BURST_INCR)) begin
      dst_addr <= dst_addr + axiwr_umi_pkg::addr_t'(beat_bytes);
    end
  end

  // Remaining bytes, forced empty on the last beat
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      bytes_left <= total_bytes;
    end else if (req_fire) begin
      if (w_last) begin
        bytes_left <= '0;
      end else begin
        bytes_left <= bytes_left - BLW'(beat_bytes);
      end
    end
  end

  assign no_bytes_left = (bytes_left == '0);

endmodule

//--- src/axiwr_ctrl.sv
//##########################################################################
// Control FSM of the write bridge
// One burst and one beat in flight at a time
// All handshakes and fire strobes come from here
//##########################################################################

`timescale 1ns/1ps

module axiwr_ctrl (
  input  logic clk,
  input  logic nreset,
  input  logic aw_valid,
  input  logic w_valid,
  input  logic req_ready,
  input  logic resp_valid,
  input  logic b_ready,
  input  logic no_bytes_left,
  output logic aw_ready,
  output logic w_ready,
  output logic req_valid,
  output logic resp_ready,
  output logic b_valid,
  output logic aw_fire,
  output logic req_fire,
  output logic resp_fire
);

  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_WRITE     = 2'd1,
    ST_WAIT_RESP = 2'd2,
    ST_SEND_B    = 2'd3
  } state_t;

  state_t state;
  state_t next_state;
  logic   b_fire;

  //########################################################################
  // Handshakes
  //########################################################################

  // Address accepted only when idle
  assign aw_ready = (state == ST_IDLE);
  assign aw_fire  = aw_valid & aw_ready;

  // Zero latency pass of the data beat onto UMI
  // UMI back-pressure stalls the AXI W channel
  assign req_valid = (state == ST_WRITE) & w_valid;
  assign w_ready   = (state == ST_WRITE) & req_ready;
  assign req_fire  = req_valid & req_ready;

  // Waiting on one response per beat
  assign resp_ready = (state == ST_WAIT_RESP);
  assign resp_fire  = resp_valid & resp_ready;

  // Held until the manager takes it
  assign b_valid = (state == ST_SEND_B);
  assign b_fire  = b_valid & b_ready;

  //########################################################################
  // State machine
  //########################################################################

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (aw_fire) begin
          next_state = ST_WRITE;
        end
      end
      ST_WRITE: begin
        if (req_fire) begin
          next_state = ST_WAIT_RESP;
        end
      end
      ST_WAIT_RESP: begin
        // More bytes means another beat, else finish the burst
        if (resp_fire) begin
          next_state = no_bytes_left ? ST_SEND_B : ST_WRITE;
        end
      end
      ST_SEND_B: begin
        if (b_fire) begin
          next_state = ST_IDLE;
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

endmodule

//--- src/axiwr_umi_pkg.sv
//##########################################################################
// Channel types for the AXI write to UMI bridge
// UMI command layout follows the bridge's own 32-bit packing
// Only opcodes, burst and response codes used by the bridge are defined
//##########################################################################

`include "axiwr_umi_settings.svh"

package axiwr_umi_pkg;

  // Basic payload types
  typedef logic [`AXIWR_AW-1:0]   addr_t;
  typedef logic [`AXIWR_DW-1:0]   data_t;
  typedef logic [`AXIWR_DW/8-1:0] strb_t;
  typedef logic [`AXIWR_IDW-1:0]  id_t;

  // Strobe byte count, 0 up to the full strobe width
  typedef logic [$clog2(`AXIWR_DW/8):0] beat_bytes_t;

  //########################################################################
  // AXI channels
  //########################################################################

  // Write address channel
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [2:0] prot;
    logic [3:0] qos;
  } axi_aw_t;

  // Write data beat
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  // Write response
  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } axi_b_t;

  //########################################################################
  // UMI channels
  //########################################################################

  // Command word, opcode in the lowest bits
  // Hostid takes whatever is left of the command width
  typedef struct packed {
    logic [`AXIWR_CW-28:0] hostid;
    logic [1:0]            err;
    logic                  ex;
    logic                  eof;
    logic                  eom;
    logic [1:0]            prot;
    logic [3:0]            qos;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [4:0]            opcode;
  } umi_cmd_t;

  // Request packet
  typedef struct packed {
    umi_cmd_t cmd;
    addr_t    dstaddr;
    addr_t    srcaddr;
    data_t    data;
  } umi_req_t;

  // Response packet, same fields as a request
  typedef struct packed {
    umi_cmd_t cmd;
    addr_t    dstaddr;
    addr_t    srcaddr;
    data_t    data;
  } umi_resp_t;

  // UMI opcodes
  localparam logic [4:0] UMI_REQ_WRITE  = 5'h03;
  localparam logic [4:0] UMI_RESP_WRITE = 5'h04;

  // AXI burst types
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- src/axiwr_umi_settings.svh
//##########################################################################
// Bridge widths and the UMI host address base
// Data width must stay at or below 128 so the strobe fits the source address
// Low strobe-width bits of the host base are replaced on every beat
//##########################################################################

`ifndef AXIWR_UMI_SETTINGS_SVH
`define AXIWR_UMI_SETTINGS_SVH

// Address width on both AXI and UMI sides
`define AXIWR_AW 64

// Data width in bits, at most 128
`define AXIWR_DW 64

// AXI ID width
`define AXIWR_IDW 8

// UMI command width
`define AXIWR_CW 32

// Source address base, low bits carry the strobe
`define AXIWR_HOSTADDR 64'h0000_0001_0000_0000

`endif

//--- src/axiwr_umi_top.sv
//##########################################################################
// AXI4 write to UMI bridge top level
// No AXI read channels and a single outstanding burst
// One UMI write request and response per AXI data beat
//##########################################################################

`timescale 1ns/1ps

module axiwr_umi_top (
  input  logic                     clk,
  input  logic                     nreset,
  // AXI write address
  input  axiwr_umi_pkg::axi_aw_t   aw,
  input  logic                     aw_valid,
  output logic                     aw_ready,
  // AXI write data
  input  axiwr_umi_pkg::axi_w_t    w,
  input  logic                     w_valid,
  output logic                     w_ready,
  // AXI write response
  output axiwr_umi_pkg::axi_b_t    b,
  output logic                     b_valid,
  input  logic                     b_ready,
  // UMI request
  output axiwr_umi_pkg::umi_req_t  req,
  output logic                     req_valid,
  input  logic                     req_ready,
  // UMI response
  input  axiwr_umi_pkg::umi_resp_t resp,
  input  logic                     resp_valid,
  output logic                     resp_ready
);

  logic                       aw_fire;
  logic                       req_fire;
  logic                       resp_fire;
  logic                       no_bytes_left;
  axiwr_umi_pkg::beat_bytes_t beat_bytes;
  axiwr_umi_pkg::addr_t       dst_addr;
  logic [1:0]                 prot;
  logic [3:0]                 qos;
  axiwr_umi_pkg::id_t         bid;
  logic [1:0]                 bresp;

  // Sequencing of all channels
  axiwr_ctrl u_ctrl (
    .clk           (clk),
    .nreset        (nreset),
    .aw_valid      (aw_valid),
    .w_valid       (w_valid),
    .req_ready     (req_ready),
    .resp_valid    (resp_valid),
    .b_ready       (b_ready),
    .no_bytes_left (no_bytes_left),
    .aw_ready      (aw_ready),
    .w_ready       (w_ready),
    .req_valid     (req_valid),
    .resp_ready    (resp_ready),
    .b_valid       (b_valid),
    .aw_fire       (aw_fire),
    .req_fire      (req_fire),
    .resp_fire     (resp_fire)
  );

  // Address and byte tracking
  axiwr_burst_track u_burst_track (
    .clk           (clk),
    .aw            (aw),
    .aw_fire       (aw_fire),
    .req_fire      (req_fire),
    .w_last        (w.last),
    .beat_bytes    (beat_bytes),
    .dst_addr      (dst_addr),
    .prot          (prot),
    .qos           (qos),
    .bid           (bid),
    .no_bytes_left (no_bytes_left)
  );

  // Beat to UMI request
  umi_req_build u_req_build (
    .w          (w),
    .dst_addr   (dst_addr),
    .prot       (prot),
    .qos        (qos),
    .req        (req),
    .beat_bytes (beat_bytes)
  );

  // Response error latch
  umi_resp_check u_resp_check (
    .clk       (clk),
    .resp      (resp),
    .aw_fire   (aw_fire),
    .resp_fire (resp_fire),
    .bresp     (bresp)
  );

  // B carries the burst ID and the latched error
  assign b.id   = bid;
  assign b.resp = bresp;

endmodule

//--- src/umi_req_build.sv
//##########################################################################
// UMI write request built from one AXI data beat
// Command size is always 0 and the byte count goes in len
// Strobes must be contiguous from bit 0
//##########################################################################

`timescale 1ns/1ps

`include "axiwr_umi_settings.svh"

module umi_req_build (
  input  axiwr_umi_pkg::axi_w_t       w,
  input  axiwr_umi_pkg::addr_t        dst_addr,
  input  logic [1:0]                  prot,
  input  logic [3:0]                  qos,
  output axiwr_umi_pkg::umi_req_t     req,
  output axiwr_umi_pkg::beat_bytes_t  beat_bytes
);

  localparam int STRBW = $bits(axiwr_umi_pkg::strb_t);
  localparam logic [`AXIWR_AW-1:0] HOSTADDR = `AXIWR_HOSTADDR;

  // Strobe must fit the 16 low source address bits
  if (STRBW > 16) begin : g_dw_check
    $error("Data width above 128 bits is not supported");
  end

  // Count of set strobe bits
  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < STRBW; i++) begin
      beat_bytes = beat_bytes + axiwr_umi_pkg::beat_bytes_t'(w.strb[i]);
    end
  end

  //########################################################################
  // Request fields
  //########################################################################

  always_comb begin
    // Unused command fields stay zero
    req             = '0;
    req.cmd.opcode  = axiwr_umi_pkg::UMI_REQ_WRITE;
    req.cmd.size    = 3'd0;
    req.cmd.len     = 8'(beat_bytes) - 8'd1;
    req.cmd.prot    = prot;
    req.cmd.qos     = qos;
    // End of message on the last AXI beat
    req.cmd.eom     = w.last;
    req.dstaddr     = dst_addr;
    // Host base with the strobe in its low bits
    req.srcaddr     = {HOSTADDR[`AXIWR_AW-1:STRBW], w.strb};
    req.data        = w.data;
  end

endmodule

//--- src/umi_resp_check.sv
//##########################################################################
// UMI response decode into an AXI BRESP code
// Error persists over the burst and the last one seen is reported
//##########################################################################

`timescale 1ns/1ps

module umi_resp_check (
  input  logic                     clk,
  input  axiwr_umi_pkg::umi_resp_t resp,
  input  logic                     aw_fire,
  input  logic                     resp_fire,
  output logic [1:0]               bresp
);

  // Cleared by each new address, valid once the burst is done
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      bresp <= axiwr_umi_pkg::RESP_OKAY;
    end else if (resp_fire) begin
      if (resp.cmd.opcode != axiwr_umi_pkg::UMI_RESP_WRITE) begin
        // Unexpected opcode
        bresp <= axiwr_umi_pkg::RESP_SLVERR;
      end else if (resp.cmd.err != 2'b00) begin
        // Target error code passes straight to BRESP
        bresp <= resp.cmd.err;
      end
    end
  end

endmodule
